// File: memwb.f
src/memwb_pkg.sv
src/memwb_stage_if.sv
src/memwb_mem_stage.sv
src/memwb_wb_stage.sv
src/memwb_regfile.sv
src/memwb_top.sv
verif/memwb_asserts.sv
verif/memwb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memwb testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module memwb_tb -Mdir obj_dir -f memwb.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vmemwb_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: verif/memwb_tb.sv
// Testbench: clock, reset, stimulus, data memory model, reference model, compare tasks, watchdog
module memwb_tb;

  localparam logic [31:0] SEED = 32'he39c_a901;
  localparam int N_ALU = 40;
  localparam int N_LOAD = 3 * 13;
  localparam int N_STORE = 30;
  localparam int N_TOTAL = N_ALU + N_LOAD + 2 * N_STORE + 8 + 4 + 4;

  typedef struct packed {
    memwb_pkg::rsd_t        dst;
    logic [31:0]            r;
    logic                   we;
    memwb_pkg::exceptions_t exc;
    logic [31:0]            badaddr;
  } expect_t;

  logic clk_i, rst_ni, valid_i, stall_o, dmem_req_o, dmem_we_o, dmem_ack_i, dmem_err_i;
  logic [31:0] instr_i, r_i, adr_i, d_i, dmem_adr_o, dmem_d_o, dmem_q_i;
  logic [31:0] wb_r_o, wb_badaddr_o, rf_rdata_o;
  logic [3:0] dmem_be_o;
  logic [memwb_pkg::EXC_W-1:0] wb_exc_o;
  logic wb_we_o, wb_retired_o;
  memwb_pkg::rsd_t wb_dst_o, rf_raddr_i;

  logic [31:0] mem [256];
  logic [31:0] ref_mem [256];
  logic [31:0] mirror [32];
  expect_t exp_q [$];
  logic [31:0] stim_rng = SEED;
  logic [31:0] delay_rng = SEED;
  int wait_cnt = 0;
  int req_count = 0;
  int exp_req = 0;

  memwb_top #(.NREGS(32)) i_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // Fill depends on every address bit
  function automatic logic [31:0] fill_word(input int i);
    logic [7:0] a;
    a = 8'(i);
    return {a ^ 8'h5a, ~a, 8'(a * 3), a + 8'h11};
  endfunction

  function automatic logic [31:0] mk_instr(input logic [4:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd);
    logic [31:0] fill;
    fill = next_rand();
    return {fill[16:0], f3, rd, opc, 2'b11};
  endfunction

  //////////////////////////////////////////////////
  // Reference model, program order
  //////////////////////////////////////////////////

  function automatic expect_t predict_result(input logic [31:0] instr, input logic [31:0] r,
                                             input logic [31:0] adr, input logic [31:0] d);
    expect_t e;
    logic [4:0] opc;
    logic [2:0] f3;
    logic [31:0] word, mask;
    logic is_ld, is_st, ill;
    int idx;
    opc = instr[6:2];
    f3 = instr[14:12];
    idx = int'(adr[9:2]);
    e = '0;
    e.dst = instr[11:7];
    e.r = r;
    is_ld = (opc == 5'b00000);
    is_st = (opc == 5'b01000);
    case (opc)
      5'b00000: ill = (f3 == 3'd3) || (f3 >= 3'd6);
      5'b01000: ill = (f3 > 3'd2);
      5'b00011, 5'b00100, 5'b00101, 5'b01100, 5'b01101,
      5'b11000, 5'b11001, 5'b11011: ill = 1'b0;
      default: ill = 1'b1;
    endcase
    if (instr[1:0] != 2'b11)
      ill = 1'b1;
    if (ill)
    begin
      e.exc.illegal_instruction = 1'b1;
      e.badaddr = instr;
    end
    else if ((is_ld || is_st) && (((f3[1:0] == 2'd1) && adr[0]) ||
                                  ((f3[1:0] == 2'd2) && (adr[1:0] != 2'd0))))
    begin
      e.exc.misaligned_load = is_ld;
      e.exc.misaligned_store = is_st;
      e.badaddr = adr;
    end
    else if (is_ld || is_st)
    begin
      exp_req++;
      if (adr[11:10] == 2'b11)
      begin
        e.exc.load_access_fault = is_ld;
        e.exc.store_access_fault = is_st;
        e.badaddr = adr;
      end
      else if (is_ld)
      begin
        word = ref_mem[idx] >> (8 * adr[1:0]);
        case (f3)
          3'd0: e.r = {{24{word[7]}}, word[7:0]};
          3'd1: e.r = {{16{word[15]}}, word[15:0]};
          3'd4: e.r = {24'h0, word[7:0]};
          3'd5: e.r = {16'h0, word[15:0]};
          default: e.r = word;
        endcase
      end
      else
      begin
        mask = (f3[1:0] == 2'd0) ? 32'hff : (f3[1:0] == 2'd1) ? 32'hffff : 32'hffff_ffff;
        mask = mask << (8 * adr[1:0]);
        ref_mem[idx] = (ref_mem[idx] & ~mask) | ((d << (8 * adr[1:0])) & mask);
      end
    end
    e.exc.any = |{e.exc.illegal_instruction, e.exc.misaligned_load, e.exc.misaligned_store,
                  e.exc.load_access_fault, e.exc.store_access_fault};
    e.we = !e.exc.any && (e.dst != 5'd0) && !is_st;
    if (e.we)
      mirror[e.dst] = e.r;
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_exc(input memwb_pkg::exceptions_t got, input memwb_pkg::exceptions_t exp);
    if (got !== exp)
      report_fail($sformatf("ERR t=%0t exception flags got %b exp %b", $time, got, exp));
  endtask

  task automatic check_data(input logic [memwb_pkg::XLEN-1:0] got,
                            input logic [memwb_pkg::XLEN-1:0] exp, input string what);
    if (got !== exp)
      report_fail($sformatf("ERR t=%0t %s got %h exp %h", $time, what, got, exp));
  endtask

  task automatic check_dst(input memwb_pkg::rsd_t got, input memwb_pkg::rsd_t exp);
    if (got !== exp)
      report_fail($sformatf("ERR t=%0t destination got %0d exp %0d", $time, got, exp));
  endtask

  // One write-back record per retired or trapped instruction, sampled mid-cycle
  always @(negedge clk_i)
  begin
    expect_t e;
    if (rst_ni && (wb_retired_o || (|wb_exc_o)))
    begin
      if (exp_q.size() == 0)
        report_fail("Write-back result seen with no instruction outstanding");
      e = exp_q.pop_front();
      check_exc(memwb_pkg::exceptions_t'(wb_exc_o), e.exc);
      check_dst(wb_dst_o, e.dst);
      check_data({31'h0, wb_retired_o}, {31'h0, !e.exc.any}, "retired");
      check_data({31'h0, wb_we_o}, {31'h0, e.we}, "write enable");
      if (e.we)
        check_data(wb_r_o, e.r, "result");
      if (e.exc.any)
        check_data(wb_badaddr_o, e.badaddr, "badaddr");
    end
  end

  //////////////////////////////////////////////////
  // Data memory model, random ack delay
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    logic [31:0] a, wd, bm;
    logic w;
    if (rst_ni && dmem_ack_i && !dmem_req_o)
    begin
      #5;
      dmem_ack_i = 1'b0;
      dmem_err_i = 1'b0;
      delay_rng = xorshift(delay_rng);
      wait_cnt = int'(delay_rng[1:0]);
    end
    else if (rst_ni && !dmem_ack_i && dmem_req_o)
    begin
      if (wait_cnt != 0)
        wait_cnt--;
      else
      begin
        a = dmem_adr_o;
        wd = dmem_d_o;
        w = dmem_we_o;
        bm = {{8{dmem_be_o[3]}}, {8{dmem_be_o[2]}}, {8{dmem_be_o[1]}}, {8{dmem_be_o[0]}}};
        req_count++;
        #5;
        dmem_err_i = (a[11:10] == 2'b11);
        dmem_q_i = mem[a[9:2]];
        if (w && !dmem_err_i)
          mem[a[9:2]] = (mem[a[9:2]] & ~bm) | (wd & bm);
        dmem_ack_i = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Hold the beat until a cycle without stall
  task automatic issue(input logic [31:0] instr, input logic [31:0] r, input logic [31:0] adr,
                       input logic [31:0] d);
    logic taken;
    exp_q.push_back(predict_result(instr, r, adr, d));
    valid_i = 1'b1;
    instr_i = instr;
    r_i = r;
    adr_i = adr;
    d_i = d;
    do
    begin
      @(negedge clk_i);
      taken = !stall_o;
      @(posedge clk_i);
      #5;
    end
    while (!taken);
    valid_i = 1'b0;
  endtask

  task automatic mem_op(input logic [4:0] opc, input logic [2:0] f3, input logic [31:0] adr);
    issue(mk_instr(opc, f3, next_rand() % 32), next_rand(), adr, next_rand());
  endtask

  initial
  begin
    logic [31:0] x;
    logic [2:0] f3s [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [1:0] off;
    rst_ni = 1'b0;
    valid_i = 1'b0;
    instr_i = '0;
    r_i = '0;
    adr_i = '0;
    d_i = '0;
    rf_raddr_i = '0;
    dmem_ack_i = 1'b0;
    dmem_err_i = 1'b0;
    dmem_q_i = '0;
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++)
      mirror[i] = '0;
    repeat (4) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    // ALU stream, rd zero included
    for (int i = 0; i < N_ALU; i++)
    begin
      x = next_rand();
      issue(mk_instr(x[0] ? 5'b01100 : 5'b00100, x[3:1], x[8:4]), next_rand(), '0, '0);
    end
    // Every load width at every legal offset
    for (int k = 0; k < 3; k++)
      for (int f = 0; f < 5; f++)
        for (int o = 0; o < 4; o++)
          if ((f3s[f][1:0] == 2'd0) || ((f3s[f][1:0] == 2'd1) && !o[0]) || (o == 0))
            mem_op(5'b00000, f3s[f], {22'h0, 8'(next_rand()), 2'(o)});
    // Stores, each checked by a word load
    for (int i = 0; i < N_STORE; i++)
    begin
      x = next_rand();
      off = (x[1:0] == 2'd0) ? x[3:2] : (x[1:0] == 2'd1) ? {x[3], 1'b0} : 2'd0;
      mem_op(5'b01000, (x[1:0] == 2'd3) ? 3'd2 : {1'b0, x[1:0]}, {22'h0, x[11:4], off});
      mem_op(5'b00000, 3'd2, {22'h0, x[11:4], 2'd0});
    end
    // Misaligned
    mem_op(5'b00000, 3'd1, 32'h0000_0041);
    mem_op(5'b00000, 3'd1, 32'h0000_0083);
    mem_op(5'b00000, 3'd5, 32'h0000_0105);
    mem_op(5'b00000, 3'd2, 32'h0000_0201);
    mem_op(5'b00000, 3'd2, 32'h0000_0302);
    mem_op(5'b00000, 3'd2, 32'h0000_0087);
    mem_op(5'b01000, 3'd1, 32'h0000_0013);
    mem_op(5'b01000, 3'd2, 32'h0000_0022);
    // Bus error region
    mem_op(5'b00000, 3'd2, 32'h0000_0c40);
    mem_op(5'b00000, 3'd0, 32'h0000_0d13);
    mem_op(5'b01000, 3'd2, 32'h0000_0e80);
    mem_op(5'b01000, 3'd0, 32'h0000_0ff1);
    // Illegal opcodes, each followed by a normal op
    issue(mk_instr(5'b00010, 3'd0, 5'd7), next_rand(), '0, '0);
    issue(mk_instr(5'b01100, 3'd0, 5'd9), next_rand(), '0, '0);
    issue(mk_instr(5'b10100, 3'd0, 5'd3), next_rand(), '0, '0);
    issue(mk_instr(5'b00100, 3'd0, 5'd11), next_rand(), '0, '0);
    while (exp_q.size() != 0)
      @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    // Register file against mirror
    for (int i = 0; i < 32; i++)
    begin
      #5;
      rf_raddr_i = 5'(i);
      #10;
      check_data(rf_rdata_o, mirror[i], $sformatf("register x%0d", i));
      @(posedge clk_i);
    end
    if (req_count != exp_req)
    begin
      $display("ERR t=%0t memory saw %0d requests, %0d expected", $time, req_count, exp_req);
      $display("TEST RESULT: FAIL");
      $fatal(1, "request count mismatch");
    end
    else
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // Worst case 40 cycles per instruction
  initial
  begin
    repeat (N_TOTAL * 40 + 100) @(posedge clk_i);
    $display("Timeout: pipeline did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verif/memwb_asserts.sv
// Bound assertions on the data memory handshake and the pipeline stall
module memwb_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       dmem_req_o,
  input logic                       dmem_we_o,
  input logic [3:0]                 dmem_be_o,
  input logic [memwb_pkg::XLEN-1:0] dmem_adr_o,
  input logic [memwb_pkg::XLEN-1:0] dmem_d_o,
  input logic                       dmem_ack_i,
  input logic                       stall_o
);

  // Request held until memory answers
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_o && !dmem_ack_i |=> dmem_req_o)
    else $error("dmem request dropped before ack");

  // No new request while the last ack is still up
  req_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(dmem_req_o) |-> !dmem_ack_i)
    else $error("dmem request raised while ack high");

  // Address, data and enables frozen while waiting
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_o && !dmem_ack_i |=> $stable(dmem_adr_o) && $stable(dmem_d_o) &&
                                  $stable(dmem_be_o) && $stable(dmem_we_o))
    else $error("dmem request fields changed while req high");

  // Stall with idle bus only for the cycle before req rises
  stall_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_o && !dmem_req_o && !dmem_ack_i |=> dmem_req_o)
    else $error("stall without request or pending ack");

endmodule

bind memwb_top memwb_asserts i_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .dmem_req_o (dmem_req_o),
  .dmem_we_o  (dmem_we_o),
  .dmem_be_o  (dmem_be_o),
  .dmem_adr_o (dmem_adr_o),
  .dmem_d_o   (dmem_d_o),
  .dmem_ack_i (dmem_ack_i),
  .stall_o    (stall_o)
);

// File: src/memwb_top.sv
// Top level: plain ports, stage interface, memory-access, write-back and register file
module memwb_top #(
  parameter int NREGS = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Executed instruction from upstream
  input  logic                        valid_i,
  input  logic [31:0]                 instr_i,
  input  logic [memwb_pkg::XLEN-1:0]  r_i,
  input  logic [memwb_pkg::XLEN-1:0]  adr_i,
  input  logic [memwb_pkg::XLEN-1:0]  d_i,
  output logic                        stall_o,

  // Data memory, four-phase
  output logic                        dmem_req_o,
  output logic                        dmem_we_o,
  output logic [3:0]                  dmem_be_o,
  output logic [memwb_pkg::XLEN-1:0]  dmem_adr_o,
  output logic [memwb_pkg::XLEN-1:0]  dmem_d_o,
  input  logic                        dmem_ack_i,
  input  logic                        dmem_err_i,
  input  logic [memwb_pkg::XLEN-1:0]  dmem_q_i,

  // Write-back results
  output memwb_pkg::rsd_t             wb_dst_o,
  output logic [memwb_pkg::XLEN-1:0]  wb_r_o,
  output logic                        wb_we_o,
  output logic [memwb_pkg::EXC_W-1:0] wb_exc_o,
  output logic [memwb_pkg::XLEN-1:0]  wb_badaddr_o,
  output logic                        wb_retired_o,

  // Register file read port
  input  memwb_pkg::rsd_t             rf_raddr_i,
  output logic [memwb_pkg::XLEN-1:0]  rf_rdata_o
);

  memwb_pkg::exceptions_t wb_exc;

  memwb_stage_if stage ();

  memwb_mem_stage i_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (valid_i),
    .instr_i    (instr_i),
    .r_i        (r_i),
    .adr_i      (adr_i),
    .d_i        (d_i),
    .stage      (stage.mem),
    .dmem_ack_i (dmem_ack_i),
    .dmem_req_o (dmem_req_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_be_o  (dmem_be_o),
    .dmem_adr_o (dmem_adr_o),
    .dmem_d_o   (dmem_d_o)
  );

  memwb_wb_stage i_wb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stage        (stage.wb),
    .dmem_ack_i   (dmem_ack_i),
    .dmem_err_i   (dmem_err_i),
    .dmem_q_i     (dmem_q_i),
    .wb_dst_o     (wb_dst_o),
    .wb_r_o       (wb_r_o),
    .wb_we_o      (wb_we_o),
    .wb_exc_o     (wb_exc),
    .wb_badaddr_o (wb_badaddr_o),
    .wb_retired_o (wb_retired_o)
  );

  memwb_regfile #(
    .NREGS (NREGS)
  ) i_rf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (wb_we_o),
    .waddr_i (wb_dst_o),
    .wdata_i (wb_r_o),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  // Back-pressure upstream follows write-back
  assign stall_o  = stage.stall;
  assign wb_exc_o = wb_exc;

endmodule

// File: src/memwb_regfile.sv
// Integer register file: one write port, one combinational read port, x0 tied to zero
module memwb_regfile #(
  parameter int NREGS = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       we_i,
  input  memwb_pkg::rsd_t            waddr_i,
  input  logic [memwb_pkg::XLEN-1:0] wdata_i,
  input  memwb_pkg::rsd_t            raddr_i,
  output logic [memwb_pkg::XLEN-1:0] rdata_o
);

  // Index bits actually used, 4 for RV32E
  localparam int AW = $clog2(NREGS);

  logic [memwb_pkg::XLEN-1:0] regs [NREGS];
  logic                       wr_ok;
  logic                       rd_ok;

  // Indices past NREGS are dropped
  assign wr_ok = we_i && (waddr_i != '0) && (int'(waddr_i) < NREGS);
  assign rd_ok = (raddr_i != '0) && (int'(raddr_i) < NREGS);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < NREGS; i++)
        regs[i] <= '0;
    end
    else if (wr_ok)
      regs[waddr_i[AW-1:0]] <= wdata_i;
  end

  // x0 and out-of-range read as zero
  assign rdata_o = rd_ok ? regs[raddr_i[AW-1:0]] : '0;

endmodule

// File: src/memwb_wb_stage.sv
// Write-back stage: memory stall, exception merge, bad address, load extraction, write control
module memwb_wb_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  memwb_stage_if.wb                  stage,
  input  logic                       dmem_ack_i,
  input  logic                       dmem_err_i,
  input  logic [memwb_pkg::XLEN-1:0] dmem_q_i,
  output memwb_pkg::rsd_t            wb_dst_o,
  output logic [memwb_pkg::XLEN-1:0] wb_r_o,
  output logic                       wb_we_o,
  output memwb_pkg::exceptions_t     wb_exc_o,
  output logic [memwb_pkg::XLEN-1:0] wb_badaddr_o,
  output logic                       wb_retired_o
);

  memwb_pkg::opcode_t         opcode;
  logic [2:0]                 funct3;
  memwb_pkg::rsd_t            dst;
  logic                       mem_op;
  logic                       ack_stale;
  logic                       ack_valid;
  memwb_pkg::exceptions_t     exc;
  logic [memwb_pkg::XLEN-1:0] q_shift;
  logic [memwb_pkg::XLEN-1:0] load_q;

  assign opcode = memwb_pkg::decode_opcode(stage.insn.instr);
  assign funct3 = memwb_pkg::decode_funct3(stage.insn.instr);
  assign dst    = memwb_pkg::decode_rd(stage.insn.instr);

  //////////////////////////////////////////////////
  // Stall
  //////////////////////////////////////////////////

  // Load or store that actually goes to memory
  assign mem_op = ~stage.insn.bubble & ~stage.exc.any &
                  ((opcode == memwb_pkg::OPC_LOAD) | (opcode == memwb_pkg::OPC_STORE));

  // Ack already consumed, still high from the previous access
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_stale <= 1'b0;
    else if (!dmem_ack_i)
      ack_stale <= 1'b0;
    else if (!stage.stall)
      ack_stale <= 1'b1;
  end

  assign ack_valid   = dmem_ack_i & ~ack_stale;
  assign stage.stall = mem_op & ~ack_valid;

  //////////////////////////////////////////////////
  // Exceptions
  //////////////////////////////////////////////////

  // Bus error becomes the access fault of this opcode
  always_comb
  begin
    exc = stage.exc;
    if (mem_op && ack_valid && dmem_err_i)
    begin
      if (opcode == memwb_pkg::OPC_LOAD)
        exc.load_access_fault = 1'b1;
      else
        exc.store_access_fault = 1'b1;
    end
    exc.any = exc.illegal_instruction | exc.misaligned_load | exc.misaligned_store |
              exc.load_access_fault | exc.store_access_fault;
  end

  // Flags of the instruction moving on, all zero while stalled
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_exc_o <= '0;
    else
      wb_exc_o <= exc;
  end

  // Address for memory faults, instruction word for illegal
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_badaddr_o <= '0;
    else if (!stage.stall)
    begin
      if (exc.misaligned_load || exc.misaligned_store ||
          exc.load_access_fault || exc.store_access_fault)
        wb_badaddr_o <= stage.adr;
      else if (exc.illegal_instruction)
        wb_badaddr_o <= stage.insn.instr;
      else
        wb_badaddr_o <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Load data
  //////////////////////////////////////////////////

  // Addressed byte down to lane 0
  assign q_shift = dmem_q_i >> {stage.adr[1:0], 3'b000};

  always_comb
  begin
    case (funct3)
      3'b000:  load_q = {{(memwb_pkg::XLEN-8){q_shift[7]}}, q_shift[7:0]};
      3'b001:  load_q = {{(memwb_pkg::XLEN-16){q_shift[15]}}, q_shift[15:0]};
      3'b100:  load_q = {{(memwb_pkg::XLEN-8){1'b0}}, q_shift[7:0]};
      3'b101:  load_q = {{(memwb_pkg::XLEN-16){1'b0}}, q_shift[15:0]};
      default: load_q = dmem_q_i;
    endcase
  end

  //////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!stage.stall)
    begin
      wb_dst_o <= dst;
      wb_r_o   <= (opcode == memwb_pkg::OPC_LOAD) ? load_q : stage.r;
    end
  end

  // No write for trapped, empty, rd zero or non-writing opcodes
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_we_o <= 1'b0;
    else if (stage.stall || stage.insn.bubble || exc.any || (dst == '0))
      wb_we_o <= 1'b0;
    else
      case (opcode)
        memwb_pkg::OPC_STORE,
        memwb_pkg::OPC_BRANCH,
        memwb_pkg::OPC_MISC_MEM: wb_we_o <= 1'b0;
        default:                 wb_we_o <= 1'b1;
      endcase
  end

  // Completed without trap, stores included
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_retired_o <= 1'b0;
    else
      wb_retired_o <= ~stage.stall & ~stage.insn.bubble & ~exc.any;
  end

endmodule

// File: src/memwb_mem_stage.sv
// Memory-access stage: issue register, illegal and alignment checks, store lanes, dmem request
module memwb_mem_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       valid_i,
  input  logic [31:0]                instr_i,
  input  logic [memwb_pkg::XLEN-1:0] r_i,
  input  logic [memwb_pkg::XLEN-1:0] adr_i,
  input  logic [memwb_pkg::XLEN-1:0] d_i,
  memwb_stage_if.mem                 stage,
  input  logic                       dmem_ack_i,
  output logic                       dmem_req_o,
  output logic                       dmem_we_o,
  output logic [3:0]                 dmem_be_o,
  output logic [memwb_pkg::XLEN-1:0] dmem_adr_o,
  output logic [memwb_pkg::XLEN-1:0] dmem_d_o
);

  logic                       bubble_q;
  logic [31:0]                instr_q;
  logic [memwb_pkg::XLEN-1:0] d_q;
  memwb_pkg::opcode_t         opcode;
  logic [2:0]                 funct3;
  memwb_pkg::mem_size_t       size;
  logic                       illegal;
  logic                       is_load;
  logic                       is_store;
  logic                       misaligned;
  logic                       access;
  logic                       done;

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  // Empty slot when upstream has nothing
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bubble_q <= 1'b1;
    else if (!stage.stall)
      bubble_q <= ~valid_i;
  end

  // Payload, frozen during stall
  always_ff @(posedge clk_i)
  begin
    if (!stage.stall)
    begin
      instr_q   <= instr_i;
      stage.r   <= r_i;
      stage.adr <= adr_i;
      d_q       <= d_i;
    end
  end

  assign stage.insn = '{bubble: bubble_q, instr: instr_q};

  assign opcode = memwb_pkg::decode_opcode(instr_q);
  assign funct3 = memwb_pkg::decode_funct3(instr_q);
  assign size   = memwb_pkg::mem_size_t'(funct3[1:0]);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Unknown major opcode or unsupported width
  always_comb
  begin
    illegal = 1'b0;
    if (instr_q[1:0] != 2'b11)
      illegal = 1'b1;
    else
      case (opcode)
        memwb_pkg::OPC_LOAD:  illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
        memwb_pkg::OPC_STORE: illegal = funct3[2] || (funct3[1:0] == 2'b11);
        memwb_pkg::OPC_OP, memwb_pkg::OPC_OP_IMM, memwb_pkg::OPC_LUI,
        memwb_pkg::OPC_AUIPC, memwb_pkg::OPC_BRANCH, memwb_pkg::OPC_JAL,
        memwb_pkg::OPC_JALR, memwb_pkg::OPC_MISC_MEM: illegal = 1'b0;
        default: illegal = 1'b1;
      endcase
  end

  assign is_load  = ~bubble_q & ~illegal & (opcode == memwb_pkg::OPC_LOAD);
  assign is_store = ~bubble_q & ~illegal & (opcode == memwb_pkg::OPC_STORE);

  // Half on odd byte, word off a word boundary
  assign misaligned = (is_load | is_store) &
                      (((size == memwb_pkg::HALF) & stage.adr[0]) |
                       ((size == memwb_pkg::WORD) & (|stage.adr[1:0])));
  assign access     = (is_load | is_store) & ~misaligned;

  always_comb
  begin
    stage.exc                     = '0;
    stage.exc.illegal_instruction = ~bubble_q & illegal;
    stage.exc.misaligned_load     = is_load & misaligned;
    stage.exc.misaligned_store    = is_store & misaligned;
    stage.exc.any                 = (~bubble_q & illegal) | misaligned;
  end

  //////////////////////////////////////////////////
  // Data memory request
  //////////////////////////////////////////////////

  // Four-phase req, drop after ack, no new req before ack is low
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dmem_req_o <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      if (dmem_req_o && dmem_ack_i)
        dmem_req_o <= 1'b0;
      else if (access && !dmem_req_o && (!done || !dmem_ack_i))
        dmem_req_o <= 1'b1;

      // Handshake closing until memory lowers ack
      if (dmem_req_o && dmem_ack_i)
        done <= 1'b1;
      else if (!dmem_ack_i)
        done <= 1'b0;
    end
  end

  // Byte enables on the addressed lanes
  always_comb
  begin
    case (size)
      memwb_pkg::BYTE: dmem_be_o = 4'b0001 << stage.adr[1:0];
      memwb_pkg::HALF: dmem_be_o = 4'b0011 << stage.adr[1:0];
      default:         dmem_be_o = 4'b1111;
    endcase
  end

  assign dmem_we_o  = is_store;
  assign dmem_adr_o = stage.adr;
  assign dmem_d_o   = d_q << {stage.adr[1:0], 3'b000}; // store data onto its lane

endmodule

// File: src/memwb_stage_if.sv
// Interface with instruction, result, address, exception flags and stall between the two stages
interface memwb_stage_if;

  // Instruction held in memory-access, bubble when empty
  memwb_pkg::instruction_t insn;

  // ALU result, passed on for non-load writes
  logic [memwb_pkg::XLEN-1:0] r;

  // Effective address of loads and stores
  logic [memwb_pkg::XLEN-1:0] adr;

  // Illegal and misaligned flags found in memory-access
  memwb_pkg::exceptions_t exc;

  // Hold from write-back while memory is busy
  logic stall;

  // Memory-access side
  modport mem (
    output insn, r, adr, exc,
    input  stall
  );

  // Write-back side
  modport wb (
    input  insn, r, adr, exc,
    output stall
  );

endinterface

// File: src/memwb_pkg.sv
// Data width, opcode enumeration, decode functions, instruction, exception and register types
package memwb_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Integer register and data width, RV32 only
  localparam int XLEN  = 32;
  // Number of flag bits in the exception record
  localparam int EXC_W = 6;

  //////////////////////////////////////////////////
  // Opcodes and field types
  //////////////////////////////////////////////////

  // Major opcode, instruction bits 6..2
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00_000,
    OPC_MISC_MEM = 5'b00_011,
    OPC_OP_IMM   = 5'b00_100,
    OPC_AUIPC    = 5'b00_101,
    OPC_STORE    = 5'b01_000,
    OPC_OP       = 5'b01_100,
    OPC_LUI      = 5'b01_101,
    OPC_BRANCH   = 5'b11_000,
    OPC_JALR     = 5'b11_001,
    OPC_JAL      = 5'b11_011
  } opcode_t;

  // Register index
  typedef logic [4:0] rsd_t;

  // Access size, funct3 bits 1..0
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } mem_size_t;

  // Instruction word plus bubble marker
  typedef struct packed {
    logic        bubble;
    logic [31:0] instr;
  } instruction_t;

  // Exception flags, badaddr travels on its own
  typedef struct packed {
    logic illegal_instruction;
    logic misaligned_load;
    logic misaligned_store;
    logic load_access_fault;
    logic store_access_fault;
    logic any;
  } exceptions_t;

  //////////////////////////////////////////////////
  // Decode helpers
  //////////////////////////////////////////////////

  function automatic opcode_t decode_opcode(input logic [31:0] instr);
    return opcode_t'(instr[6:2]);
  endfunction

  // Destination register, bits 11..7
  function automatic rsd_t decode_rd(input logic [31:0] instr);
    return instr[11:7];
  endfunction

  // funct3, bits 14..12
  function automatic logic [2:0] decode_funct3(input logic [31:0] instr);
    return instr[14:12];
  endfunction

endpackage
